// ==== event_logger.f ====
+incdir+bench
rtl/logger_cfg_pkg.sv
rtl/logger_rec_pkg.sv
rtl/logger_config.sv
rtl/ts_capture_chn.sv
rtl/record_arbiter.sv
rtl/event_logger_top.sv
bench/tb_event_logger.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the event logger testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_event_logger -Mdir obj_dir -f event_logger.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_event_logger)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "NO ERRORS"; then
    exit 0
fi
echo "simulation did not pass"
exit 1

// ==== bench/tb_logger_tasks.svh ====
// event logger testbench tasks
// command and timestamp drivers, bounded waits, value checks and directed tests

    // one clock, then the drive delay
    task automatic drive_edge();
        @(posedge xclk);
        #DRV_DLY;
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("CHECK FAILED %s expected 'h%0h actual 'h%0h", name, exp, act);
        end
    endtask

    // config word built from the documented bit positions
    function automatic logic [31:0] conf_word(input logic [4:0] syn, input logic syn_we,
                                              input logic off, input logic off_we);
        logic [31:0] w;
        w = '0;
        w[logger_cfg_pkg::CONF_SYN_LSB +: 5]    = syn;
        w[logger_cfg_pkg::CONF_SYN_WE]          = syn_we;
        w[logger_cfg_pkg::CONF_OFF_BIT]         = off;
        w[logger_cfg_pkg::CONF_OFF_WE]          = off_we;
        return w;
    endfunction

    // single write, returns once the registered enables follow
    task automatic write_cmd(input logic [6:0] addr, input logic [31:0] data);
        drive_edge();
        i_cmd_we   = 1'b1;
        i_cmd_addr = addr;
        i_cmd_data = data;
        drive_edge();
        i_cmd_we   = 1'b0;
        repeat (2) drive_edge(); // mask, then enables
    endtask

    task automatic pulse_sof(input logic [NUM_SOF_CHN-1:0] mask);
        drive_edge();
        i_sof = mask;
        drive_edge();
        i_sof = '0;
    endtask

    // strobe on all masked channels at once, then eight random bytes each
    task automatic send_ts(input logic [NUM_CHN-1:0] mask);
        drive_edge();
        i_ts_stb = mask;
        for (int c = 0; c < NUM_CHN; c++) begin
            for (int b = 0; b < logger_rec_pkg::TS_BYTES; b++) begin
                if (mask[c]) ts_bytes[c][b] = 8'($random(seed));
            end
        end
        for (int b = 0; b < logger_rec_pkg::TS_BYTES; b++) begin
            drive_edge();
            i_ts_stb = '0;
            for (int c = 0; c < NUM_CHN; c++) begin
                i_ts_data[c] = mask[c] ? ts_bytes[c][b] : 8'h00;
            end
        end
        drive_edge();
        i_ts_data = '0;
    endtask

    task automatic wait_words(input string name, input int n);
        int t;
        t = 0;
        while (words.size() < n && t < WAIT_MAX) begin
            drive_edge();
            t++;
        end
        if (words.size() < n) begin
            errors++;
            $display("%s: timed out with %0d output words, %0d expected", name, words.size(), n);
        end
    endtask

    task automatic wait_quiet(input int cycles);
        for (int t = 0; t < cycles; t++) begin
            drive_edge();
        end
    endtask

    // s0 is the low byte of sec, u0 the low byte of usec, u3 not sent
    task automatic check_record(input string name, input int idx, input int chn);
        logic [31:0] sec;
        logic [23:0] usec;
        sec  = {ts_bytes[chn][3], ts_bytes[chn][2], ts_bytes[chn][1], ts_bytes[chn][0]};
        usec = {ts_bytes[chn][6], ts_bytes[chn][5], ts_bytes[chn][4]};
        if (words.size() < idx + 4) begin
            errors++;
            $display("%s: record of channel %0d missing from the output", name, chn);
        end else begin
            check_value({name, " w0"}, 32'(usec[15:0]), 32'(words[idx]));
            check_value({name, " w1"}, {16'h0, 5'h0, 3'(chn), usec[23:16]},
                        32'(words[idx + 1]));
            check_value({name, " w2"}, 32'(sec[15:0]), 32'(words[idx + 2]));
            check_value({name, " w3"}, 32'(sec[31:16]), 32'(words[idx + 3]));
        end
    endtask

    task automatic test_off_after_reset();
        write_cmd(logger_cfg_pkg::ADDR_CONFIG, conf_word(5'b11111, 1'b1, 1'b0, 1'b0));
        pulse_sof('1);
        send_ts('1);
        wait_quiet(QUIET);
        check_value("off_after_reset words", 0, words.size());
        check_value("off_after_reset count", 0, 32'(o_sample_count));
    endtask

    task automatic test_single_record();
        int base;
        base = words.size();
        write_cmd(logger_cfg_pkg::ADDR_CONFIG, conf_word(5'b10000, 1'b1, 1'b0, 1'b1));
        send_ts(5'b10000);
        wait_words("single_record", base + 4);
        wait_quiet(QUIET);
        check_value("single_record words", base + 4, words.size());
        check_record("single_record", base, 4);
        check_value("single_record count", 1, 32'(o_sample_count));
    endtask

    task automatic test_sof_filter();
        int base;
        int cnt0;
        base = words.size();
        cnt0 = int'(o_sample_count);
        write_cmd(logger_cfg_pkg::ADDR_CONFIG, conf_word(5'b10010, 1'b1, 1'b0, 1'b0));
        send_ts(5'b00010);
        send_ts(5'b00010);
        wait_quiet(QUIET);
        check_value("sof_filter unarmed", base, words.size());
        pulse_sof(4'b0010);
        send_ts(5'b00010);
        wait_words("sof_filter chn1", base + 4);
        check_record("sof_filter chn1", base, 1);
        send_ts(5'b00010); // same frame, dropped
        wait_quiet(QUIET);
        check_value("sof_filter one per frame", base + 4, words.size());
        send_ts(5'b10000);
        wait_words("sof_filter chn4 first", base + 8);
        check_record("sof_filter chn4 first", base + 4, 4);
        send_ts(5'b10000);
        wait_words("sof_filter chn4 second", base + 12);
        wait_quiet(QUIET);
        check_value("sof_filter words", base + 12, words.size());
        check_record("sof_filter chn4 second", base + 8, 4);
        check_value("sof_filter count", cnt0 + 3, 32'(o_sample_count));
    endtask

    task automatic test_same_cycle();
        int base;
        int cnt0;
        base = words.size();
        cnt0 = int'(o_sample_count);
        write_cmd(logger_cfg_pkg::ADDR_CONFIG, conf_word(5'b10101, 1'b1, 1'b0, 1'b0));
        pulse_sof(4'b0101); // both sof channels armed
        send_ts(5'b10101);
        wait_words("same_cycle", base + 12);
        wait_quiet(QUIET);
        check_value("same_cycle words", base + 12, words.size());
        check_record("same_cycle chn0", base, 0);
        check_record("same_cycle chn2", base + 4, 2);
        check_record("same_cycle chn4", base + 8, 4);
        check_value("same_cycle count", cnt0 + 3, 32'(o_sample_count));
    endtask

    task automatic test_config_writes();
        int base;
        int cnt0;
        base = words.size();
        cnt0 = int'(o_sample_count);
        write_cmd(7'd4, conf_word(5'b00000, 1'b1, 1'b1, 1'b1)); // not the config address
        send_ts(5'b10000);
        wait_words("config_writes other addr", base + 4);
        check_record("config_writes other addr", base, 4);
        check_value("config_writes other addr count", cnt0 + 1, 32'(o_sample_count));
        write_cmd(logger_cfg_pkg::ADDR_CONFIG, conf_word(5'b00000, 1'b0, 1'b1, 1'b0));
        send_ts(5'b10000);
        wait_words("config_writes off no we", base + 8);
        check_record("config_writes off no we", base + 4, 4);
        check_value("config_writes off no we count", cnt0 + 2, 32'(o_sample_count));
        write_cmd(logger_cfg_pkg::ADDR_CONFIG, conf_word(5'b00000, 1'b0, 1'b1, 1'b1));
        check_value("config_writes off count", 0, 32'(o_sample_count));
        pulse_sof('1);
        send_ts('1);
        wait_quiet(QUIET);
        check_value("config_writes off words", base + 8, words.size());
        check_value("config_writes off count held", 0, 32'(o_sample_count));
    endtask

// ==== bench/tb_event_logger.sv ====
// event logger testbench
// drives the command port and the timestamp channels, collects the word stream
`timescale 1ns/100ps
`default_nettype none

module tb_event_logger;

    localparam int NUM_CHN     = 5;
    localparam int NUM_SOF_CHN = 4;
    localparam int DRV_DLY     = 2;   // ns after the rising edge
    localparam int WAIT_MAX    = 100; // cycles before a wait gives up
    localparam int QUIET       = 40;  // cycles that must pass with no new output

    logic                                  xclk;
    logic                                  config_rst;
    logic                                  i_cmd_we;
    logic [logger_cfg_pkg::CMD_ADDR_W-1:0] i_cmd_addr;
    logic [logger_cfg_pkg::CMD_DATA_W-1:0] i_cmd_data;
    logic [NUM_SOF_CHN-1:0]                i_sof;
    logic [NUM_CHN-1:0]                    i_ts_stb;
    logic [NUM_CHN-1:0][7:0]               i_ts_data;
    logic [15:0]                           o_data;
    logic                                  o_data_stb;
    logic [23:0]                           o_sample_count;

    logic [15:0] words[$];  // output words in arrival order
    int          errors;    // failed checks and timeouts
    int          checks;    // checks run
    integer      seed;      // $random state
    logic [7:0]  ts_bytes [NUM_CHN][logger_rec_pkg::TS_BYTES]; // last message per channel

    event_logger_top #(
        .NUM_CHN     (NUM_CHN),
        .NUM_SOF_CHN (NUM_SOF_CHN)
    ) u_dut (
        .xclk           (xclk),
        .config_rst     (config_rst),
        .i_cmd_we       (i_cmd_we),
        .i_cmd_addr     (i_cmd_addr),
        .i_cmd_data     (i_cmd_data),
        .i_sof          (i_sof),
        .i_ts_stb       (i_ts_stb),
        .i_ts_data      (i_ts_data),
        .o_data         (o_data),
        .o_data_stb     (o_data_stb),
        .o_sample_count (o_sample_count)
    );

    initial begin
        xclk = 1'b0;
        forever #20 xclk = ~xclk; // 40 ns period
    end

    // output monitor, words are stable mid-cycle
    always @(negedge xclk) begin
        if (!config_rst && o_data_stb) begin
            words.push_back(o_data);
        end
    end

    `include "tb_logger_tasks.svh"

    initial begin
        seed       = 32'hcec6;
        errors     = 0;
        checks     = 0;
        config_rst = 1'b1;
        i_cmd_we   = 1'b0;
        i_cmd_addr = '0;
        i_cmd_data = '0;
        i_sof      = '0;
        i_ts_stb   = '0;
        i_ts_data  = '0;
        repeat (16) @(posedge xclk);
        #DRV_DLY config_rst = 1'b0;
        wait_quiet(4);

        test_off_after_reset();
        test_single_record();
        test_sof_filter();
        test_same_cycle();
        test_config_writes();

        $display("tb_event_logger: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/event_logger_top.sv ====
// event logger, external timestamp path
// configuration register, generated capture channels and the record arbiter
// producing a 16-bit word stream
`timescale 1ns/100ps
`default_nettype none

module event_logger_top #(
    parameter int NUM_CHN     = 5, // timestamp channels, last one is the trigger input
    parameter int NUM_SOF_CHN = 4  // channels with sof filtering
) (
    input  wire logic                                  xclk,
    input  wire logic                                  config_rst,     // sync, active high
    input  wire logic                                  i_cmd_we,
    input  wire logic [logger_cfg_pkg::CMD_ADDR_W-1:0] i_cmd_addr,
    input  wire logic [logger_cfg_pkg::CMD_DATA_W-1:0] i_cmd_data,
    input  wire logic [NUM_SOF_CHN-1:0]                i_sof,          // per-channel start of frame
    input  wire logic [NUM_CHN-1:0]                    i_ts_stb,       // one cycle before data
    input  wire logic [NUM_CHN-1:0][7:0]               i_ts_data,      // serial timestamp bytes
    output logic      [15:0]                           o_data,
    output logic                                       o_data_stb,
    output logic      [23:0]                           o_sample_count
);

    logger_cfg_pkg::cmd_word_u                cmd_word;   // command data, raw view
    logic [NUM_CHN-1:0]                       chn_en;     // enables after logger off
    logic                                     logger_off;
    logic [NUM_CHN-1:0]                       chn_sof;    // sof, zero above NUM_SOF_CHN
    logger_rec_pkg::chn_state_t [NUM_CHN-1:0] chn_state;
    logic [NUM_CHN-1:0]                       chn_clear;

    assign cmd_word.raw = i_cmd_data;
    assign chn_sof      = NUM_CHN'(i_sof);

    logger_config #(.NUM_CHN(NUM_CHN)) u_config (
        .xclk         (xclk),
        .config_rst   (config_rst),
        .i_cmd_we     (i_cmd_we),
        .i_cmd_addr   (i_cmd_addr),
        .i_cmd_data   (cmd_word),
        .o_chn_en     (chn_en),
        .o_logger_off (logger_off)
    );

    for (genvar c = 0; c < NUM_CHN; c++) begin : g_chn
        ts_capture_chn #(.USE_SOF(c < NUM_SOF_CHN)) u_chn (
            .xclk       (xclk),
            .config_rst (config_rst),
            .i_en       (chn_en[c]),
            .i_sof      (chn_sof[c]),
            .i_ts_stb   (i_ts_stb[c]),
            .i_ts_data  (i_ts_data[c]),
            .i_clear    (chn_clear[c]),
            .o_state    (chn_state[c])
        );
    end

    record_arbiter #(.NUM_CHN(NUM_CHN)) u_arbiter (
        .xclk           (xclk),
        .config_rst     (config_rst),
        .i_logger_off   (logger_off),
        .i_chn_state    (chn_state),
        .o_clear        (chn_clear),
        .o_data         (o_data),
        .o_data_stb     (o_data_stb),
        .o_sample_count (o_sample_count)
    );

endmodule

`default_nettype wire

// ==== rtl/record_arbiter.sv ====
// record arbiter
// takes ready channels by fixed priority, sends each record as four
// 16-bit words and counts the records sent
`timescale 1ns/100ps
`default_nettype none

module record_arbiter #(
    parameter int NUM_CHN = 5 // number of timestamp channels
) (
    input  wire logic                                    xclk,
    input  wire logic                                    config_rst,     // sync, active high
    input  wire logic                                    i_logger_off,   // no new records
    input  wire logger_rec_pkg::chn_state_t [NUM_CHN-1:0] i_chn_state,
    output logic      [NUM_CHN-1:0]                      o_clear,        // record taken
    output logic      [15:0]                             o_data,
    output logic                                         o_data_stb,     // one per word
    output logic      [23:0]                             o_sample_count  // records sent
);

    localparam int CHN_W  = logger_rec_pkg::CHN_W;
    localparam int NWORDS = logger_rec_pkg::REC_WORDS;
    localparam int WIDX_W = $clog2(NWORDS);

    logic                       any_ready; // some channel holds a record
    logic [CHN_W-1:0]           pick;      // lowest ready channel
    logic                       busy_q;    // sending a record
    logic [WIDX_W-1:0]          widx_q;    // word being sent
    logic                       last_word; // word 3 on the output
    logic [CHN_W-1:0]           chn_q;     // channel being sent
    logger_rec_pkg::ts_record_t rec_q;     // record being sent

    // fixed priority with channel 0 first
    always_comb begin
        any_ready = 1'b0;
        pick      = '0;
        for (int c = NUM_CHN - 1; c >= 0; c--) begin
            if (i_chn_state[c].ready) begin
                any_ready = 1'b1;
                pick      = CHN_W'(c);
            end
        end
    end

    assign last_word = busy_q && (widx_q == WIDX_W'(NWORDS - 1));

    // word sequencer rechecks channels only once idle
    always_ff @(posedge xclk) begin
        if (config_rst) begin
            busy_q <= 1'b0;
            widx_q <= '0;
        end else if (busy_q) begin
            widx_q <= widx_q + 1'b1;
            if (last_word) begin
                busy_q <= 1'b0;                // current record finishes even when off
            end
        end else if (any_ready && !i_logger_off) begin
            busy_q <= 1'b1;
            widx_q <= '0;
        end
    end

    // record and channel held while sending
    always_ff @(posedge xclk) begin
        if (!busy_q && any_ready) begin
            chn_q <= pick;
            rec_q <= i_chn_state[pick].rec;
        end
    end

    // record counter held at zero while logger off
    always_ff @(posedge xclk) begin
        if (config_rst || i_logger_off) begin
            o_sample_count <= '0;
        end else if (last_word) begin
            o_sample_count <= o_sample_count + 1'b1;
        end
    end

    // clear goes out with the last word
    always_comb begin
        o_clear = '0;
        if (last_word) begin
            o_clear[chn_q] = 1'b1;
        end
    end

    // word formatting
    always_comb begin
        case (widx_q)
            WIDX_W'(logger_rec_pkg::WORD_USEC_LO): o_data = rec_q.usec[15:0];
            WIDX_W'(logger_rec_pkg::WORD_USEC_HI): o_data = {{(8 - CHN_W){1'b0}}, chn_q,
                                                             rec_q.usec[23:16]};
            WIDX_W'(logger_rec_pkg::WORD_SEC_LO):  o_data = rec_q.sec[15:0];
            default:                               o_data = rec_q.sec[31:16];
        endcase
    end

    assign o_data_stb = busy_q;

    // one clear per record, and the latched channel must map onto a real clear line
    a_clear_onehot: assert property (
        @(posedge xclk) disable iff (config_rst)
        $onehot0(o_clear) && (last_word == (o_clear != '0))
    );

endmodule

`default_nettype wire

// ==== rtl/ts_capture_chn.sv ====
// timestamp capture channel
// assembles an eight-byte serial timestamp into one record and holds it
// until the arbiter clears it, optional start-of-frame filter
`timescale 1ns/100ps
`default_nettype none

module ts_capture_chn #(
    parameter bit USE_SOF = 1'b1 // accept only the first timestamp after sof
) (
    input  wire logic                        xclk,
    input  wire logic                        config_rst,  // sync, active high
    input  wire logic                        i_en,        // low clears the channel
    input  wire logic                        i_sof,       // start of frame, arms the channel
    input  wire logic                        i_ts_stb,    // one cycle before the first byte
    input  wire logic [7:0]                  i_ts_data,   // s0..s3, u0..u3
    input  wire logic                        i_clear,     // record taken by arbiter
    output logger_rec_pkg::chn_state_t       o_state
);

    localparam int NBYTES = logger_rec_pkg::TS_BYTES;
    localparam int CNT_W  = $clog2(NBYTES + 1);
    localparam int SR_W   = 8 * (NBYTES - 1); // last byte (u3) is not kept

    logic             busy_q;    // capture in progress
    logic             ready_q;   // record complete
    logic             armed;     // sof filter allows a strobe
    logic             accept;    // strobe starts a capture
    logic [CNT_W-1:0] byte_cnt;  // bytes taken so far
    logic [SR_W-1:0]  shift_q;   // s0 ends up in the low byte

    // strobes are lost while busy or holding a record
    assign accept = i_ts_stb && i_en && armed && !busy_q && !ready_q;

    generate
        if (USE_SOF) begin : g_sof
            logic armed_q;
            always_ff @(posedge xclk) begin
                if (config_rst || !i_en) begin
                    armed_q <= 1'b0;
                end else if (i_sof) begin
                    armed_q <= 1'b1;  // sof wins over a same-cycle strobe
                end else if (accept) begin
                    armed_q <= 1'b0;  // one timestamp per frame
                end
            end
            assign armed = armed_q;
        end else begin : g_no_sof
            assign armed = 1'b1;      // trigger input takes every timestamp
        end
    endgenerate

    // capture control, ready rises one cycle after the last byte
    always_ff @(posedge xclk) begin
        if (config_rst || !i_en) begin
            busy_q   <= 1'b0;
            ready_q  <= 1'b0;
            byte_cnt <= '0;
        end else if (accept) begin
            busy_q   <= 1'b1;
            byte_cnt <= '0;
        end else if (busy_q) begin
            if (byte_cnt == CNT_W'(NBYTES)) begin
                busy_q  <= 1'b0;
                ready_q <= 1'b1;
            end else begin
                byte_cnt <= byte_cnt + 1'b1;
            end
        end else if (i_clear) begin
            ready_q <= 1'b0;
        end
    end

    // byte shifter, new bytes enter at the top
    always_ff @(posedge xclk) begin
        if (busy_q && (byte_cnt < CNT_W'(NBYTES - 1))) begin
            shift_q <= {i_ts_data, shift_q[SR_W-1:8]};
        end
    end

    assign o_state.ready    = ready_q;
    assign o_state.rec.sec  = shift_q[31:0];              // s3..s0
    assign o_state.rec.usec = shift_q[SR_W-1:32];         // u2..u0

    a_ready_not_busy: assert property (
        @(posedge xclk) disable iff (config_rst)
        busy_q |-> !ready_q
    );

    // a clear must find the record still there, unless the channel was disabled
    // while the arbiter was sending it
    a_clear_when_ready: assert property (
        @(posedge xclk) disable iff (config_rst)
        (i_en [*logger_rec_pkg::REC_WORDS + 1]) ##0 i_clear |-> ready_q
    );

endmodule

`default_nettype wire

// ==== rtl/logger_config.sv ====
// logger configuration register
// decodes command port writes, keeps the sync enable mask and the logger off bit,
// drives registered per-channel enables
`timescale 1ns/100ps
`default_nettype none

module logger_config #(
    parameter int NUM_CHN = 5 // number of timestamp channels
) (
    input  wire logic                                xclk,
    input  wire logic                                config_rst,   // sync, active high
    input  wire logic                                i_cmd_we,     // one write per cycle
    input  wire logic [logger_cfg_pkg::CMD_ADDR_W-1:0] i_cmd_addr,
    input  wire logger_cfg_pkg::cmd_word_u           i_cmd_data,
    output logic      [NUM_CHN-1:0]                  o_chn_en,     // per-channel capture enable
    output logic                                     o_logger_off  // to arbiter
);

    logic                           wr_conf;    // write to the config address
    logger_cfg_pkg::conf_word_t     conf;       // command seen as config fields
    logic [NUM_CHN-1:0]             syn_mask;   // stored sync enables
    logic                           logger_off; // stored off bit

    assign wr_conf = i_cmd_we && (i_cmd_addr == logger_cfg_pkg::ADDR_CONFIG);
    assign conf    = i_cmd_data.conf;

    // register fields, each under its own write enable
    always_ff @(posedge xclk) begin
        if (config_rst) begin
            syn_mask   <= '0;   // all channels off
            logger_off <= 1'b1; // logger starts stopped
        end else if (wr_conf) begin
            if (conf.syn_we) begin
                syn_mask <= conf.syn[NUM_CHN-1:0];
            end
            if (conf.off_we) begin
                logger_off <= conf.off;
            end
        end
    end

    // second stage, logger off overrides every channel enable
    always_ff @(posedge xclk) begin
        if (config_rst) begin
            o_chn_en     <= '0;
            o_logger_off <= 1'b1;
        end else begin
            o_chn_en     <= logger_off ? '0 : syn_mask;
            o_logger_off <= logger_off;
        end
    end

    // channels must never run while the logger is off, also seen by the arbiter
    a_off_disables: assert property (
        @(posedge xclk) disable iff (config_rst)
        o_logger_off |-> (o_chn_en == '0)
    );

endmodule

`default_nettype wire

// ==== rtl/logger_rec_pkg.sv ====
// timestamp record definitions
// record layout, output word count and channel number width
`default_nettype none

package logger_rec_pkg;

    parameter int TS_BYTES  = 8; // s0..s3, u0..u3, lsb first
    parameter int REC_WORDS = 4; // 16-bit words per output record
    parameter int CHN_W     = 3; // channel number width in word 1

    parameter int SEC_W  = 32; // seconds
    parameter int USEC_W = 24; // microseconds, u3 is dropped

    // one captured timestamp
    typedef struct packed {
        logic [SEC_W-1:0]  sec;
        logic [USEC_W-1:0] usec;
    } ts_record_t;

    // what a channel shows the arbiter
    typedef struct packed {
        logic       ready; // record complete, waiting to be sent
        ts_record_t rec;
    } chn_state_t;

    // record word order on the output
    //   0: usec[15:0]
    //   1: {chn, usec[23:16]}
    //   2: sec[15:0]
    //   3: sec[31:16]
    parameter int WORD_USEC_LO = 0;
    parameter int WORD_USEC_HI = 1;
    parameter int WORD_SEC_LO  = 2;
    parameter int WORD_SEC_HI  = 3;

endpackage

`default_nettype wire

// ==== rtl/logger_cfg_pkg.sv ====
// logger command port definitions
// command addresses, configuration bit positions and the command word layout
`default_nettype none

package logger_cfg_pkg;

    parameter int CMD_ADDR_W   = 7;  // command address width
    parameter int CMD_DATA_W   = 32; // command data width

    parameter logic [CMD_ADDR_W-1:0] ADDR_CONFIG = 7'd3; // configuration register

    // configuration word bit positions
    parameter int CONF_SYN_LSB  = 14; // sync enable mask, one bit per channel
    parameter int CONF_SYN_BITS = 5;  // width of the sync enable mask
    parameter int CONF_SYN_WE   = 19; // mask write enable
    parameter int CONF_OFF_BIT  = 20; // logger off
    parameter int CONF_OFF_WE   = 21; // logger off write enable

    // configuration word, msb first
    typedef struct packed {
        logic [CMD_DATA_W-1:CONF_OFF_WE+1] rsvd_hi; // unused upper bits
        logic                              off_we;  // update off bit
        logic                              off;     // logger off
        logic                              syn_we;  // update syn mask
        logic [CONF_SYN_BITS-1:0]          syn;     // per-channel sync enable
        logic [CONF_SYN_LSB-1:0]           rsvd_lo; // unused lower bits
    } conf_word_t;

    // one command word, seen raw or as the configuration layout
    typedef union packed {
        logic [CMD_DATA_W-1:0] raw;
        conf_word_t            conf;
    } cmd_word_u;

endpackage

`default_nettype wire
